// ==== Makefile ====
TOP = tbLoadStore

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f logic/*.sv tb/*.sv tb/*.svh
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)
	verilator --lint-only --assert \
		logic/loadStorePkg.sv \
		logic/regFile.sv \
		logic/addressGen.sv \
		logic/dataMemory.sv \
		logic/sequencer.sv \
		logic/loadStoreCore.sv \
		--top-module loadStoreCore

clean:
	rm -rf obj_dir sim.log

// ==== logic/addressGen.sv ====
`timescale 1ns/1ps

module addressGen (
    input  logic                      Clock,
    input  logic                      rst,
    input  logic                      capture,
    input  loadStorePkg::dataWord     baseValue,
    input  loadStorePkg::displacement offset,
    output loadStorePkg::dataWord     effAddress
);
    import loadStorePkg::*;

    localparam int ExtendBits = $bits(dataWord) - $bits(displacement);

    dataWord extended;
    dataWord sum;

    // Sign extension of C to a full word
    assign extended = {{ExtendBits{offset[$bits(displacement)-1]}}, offset};

    // Wraps modulo 2**32
    assign sum = baseValue + extended;

    // Stands in for the Y, Z and MAR register chain
    always_ff @(posedge Clock) begin
        if (rst) begin
            effAddress <= '0;
        end else if (capture) begin
            effAddress <= sum;
        end
    end

endmodule

// ==== logic/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory #(
    parameter int MemAddrWidth = 9
) (
    input  logic                   Clock,
    input  loadStorePkg::memAccess access,
    output loadStorePkg::dataWord  readData
);
    import loadStorePkg::*;

    localparam int Depth = 2 ** MemAddrWidth;

    dataWord                 mem [Depth];
    logic [MemAddrWidth-1:0] wordIndex;

    // Upper address bits alias onto the same words
    assign wordIndex = access.address[MemAddrWidth-1:0];

    // One access per cycle, readData holds until the next read
    always_ff @(posedge Clock) begin
        if (access.enable) begin
            if (access.write) begin
                mem[wordIndex] <= access.data;
            end else begin
                readData <= mem[wordIndex];
            end
        end
    end

    // Write strobe comes from the sequencer only inside an access
    writeNeedsEnable: assert property (
        @(posedge Clock)
        access.write |-> access.enable
    ) else $error("memory write without enable at address %0h", access.address);

endmodule

// ==== logic/loadStoreCore.sv ====
`timescale 1ns/1ps

module loadStoreCore #(
    parameter int MemAddrWidth = 9
) (
    input  logic                      Clock,
    input  logic                      rst,
    input  logic                      instrValid,
    output logic                      instrReady,
    input  loadStorePkg::instruction  instr,
    output logic                      retireValid,
    input  logic                      retireReady,
    output loadStorePkg::retireRecord retire
);
    import loadStorePkg::*;

    regIndex     baseIndex;
    regIndex     dataIndex;
    displacement offset;
    logic        capture;
    dataWord     baseValue;
    dataWord     storeValue;
    dataWord     effAddress;
    dataWord     readData;
    memAccess    access;
    regWrite     write;

    sequencer u_sequencer (
        .Clock       (Clock),
        .rst         (rst),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .instr       (instr),
        .retireValid (retireValid),
        .retireReady (retireReady),
        .retire      (retire),
        .baseIndex   (baseIndex),
        .dataIndex   (dataIndex),
        .offset      (offset),
        .capture     (capture),
        .effAddress  (effAddress),
        .storeValue  (storeValue),
        .readData    (readData),
        .access      (access),
        .write       (write)
    );

    // Store data source
    regFile u_regFile (
        .Clock      (Clock),
        .rst        (rst),
        .baseIndex  (baseIndex),
        .dataIndex  (dataIndex),
        .write      (write),
        .baseValue  (baseValue),
        .storeValue (storeValue)
    );

    // Effective address source
    addressGen u_addressGen (
        .Clock      (Clock),
        .rst        (rst),
        .capture    (capture),
        .baseValue  (baseValue),
        .offset     (offset),
        .effAddress (effAddress)
    );

    // Joins address and store data into one access
    dataMemory #(
        .MemAddrWidth (MemAddrWidth)
    ) u_dataMemory (
        .Clock    (Clock),
        .access   (access),
        .readData (readData)
    );

endmodule

// ==== logic/loadStorePkg.sv ====
package loadStorePkg;

    // One register or memory word
    typedef logic [31:0] dataWord;

    // Register number, sixteen registers
    typedef logic [3:0] regIndex;

    // Constant field C of the instruction
    typedef logic signed [18:0] displacement;

    typedef enum logic [4:0] {
        opLoad    = 5'd0,   // ld  ra, C(rb)
        opLoadImm = 5'd1,   // ldi ra, C(rb)
        opStore   = 5'd2    // st  C(rb), ra
    } opcode;

    typedef enum logic [2:0] {
        stIdle,
        stAddress,      // Base plus displacement
        stMemory,       // Read or write issued
        stWriteback,    // Register write, record offered
        stRetire        // Record held under back-pressure
    } seqState;

    // Field order matches the instruction word, op in the top bits
    typedef struct packed {
        opcode       op;
        regIndex     ra;
        regIndex     rb;
        displacement c;
    } instruction;

    typedef struct packed {
        logic    enable;
        regIndex index;
        dataWord value;
    } regWrite;

    typedef struct packed {
        logic    enable;
        logic    write;     // High for a store, low for a read
        dataWord address;   // Full address, memory decodes the low bits
        dataWord data;
    } memAccess;

    typedef struct packed {
        opcode   op;
        regIndex ra;
        dataWord address;   // Effective address
        dataWord value;     // Loaded word, address for ldi, stored word for st
    } retireRecord;

endpackage

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                  Clock,
    input  logic                  rst,
    input  loadStorePkg::regIndex baseIndex,
    input  loadStorePkg::regIndex dataIndex,
    input  loadStorePkg::regWrite write,
    output loadStorePkg::dataWord baseValue,
    output loadStorePkg::dataWord storeValue
);
    import loadStorePkg::*;

    localparam int RegCount = 16;

    dataWord regs [RegCount];

    always_ff @(posedge Clock) begin
        if (rst) begin
            regs <= '{default: '0};     // All registers start at zero
        end else if (write.enable) begin
            regs[write.index] <= write.value;
        end
    end

    // r0 as a base reads as zero, the address rule of the ISA
    always_comb begin
        if (baseIndex == regIndex'(0)) begin
            baseValue = '0;
        end else begin
            baseValue = regs[baseIndex];
        end
    end

    // True contents, so r0 can still be stored
    assign storeValue = regs[dataIndex];

    // The sequencer must never write back an unknown result
    writeValueKnown: assert property (
        @(posedge Clock) disable iff (rst)
        write.enable |-> !$isunknown(write.value)
    ) else $error("register write of unknown value to r%0d", write.index);

endmodule

// ==== logic/sequencer.sv ====
`timescale 1ns/1ps

module sequencer (
    input  logic                      Clock,
    input  logic                      rst,
    input  logic                      instrValid,
    output logic                      instrReady,
    input  loadStorePkg::instruction  instr,
    output logic                      retireValid,
    input  logic                      retireReady,
    output loadStorePkg::retireRecord retire,
    output loadStorePkg::regIndex     baseIndex,
    output loadStorePkg::regIndex     dataIndex,
    output loadStorePkg::displacement offset,
    output logic                      capture,
    input  loadStorePkg::dataWord     effAddress,
    input  loadStorePkg::dataWord     storeValue,
    input  loadStorePkg::dataWord     readData,
    output loadStorePkg::memAccess    access,
    output loadStorePkg::regWrite     write
);
    import loadStorePkg::*;

    seqState    state;
    seqState    nextState;
    instruction held;           // Instruction in flight
    dataWord    storeData;      // Word sent to memory by st
    dataWord    resultValue;
    logic       accepted;
    logic       retired;

    assign accepted    = instrValid && instrReady;
    assign retired     = retireValid && retireReady;
    assign instrReady  = (state == stIdle);
    assign retireValid = (state == stWriteback) || (state == stRetire);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (accepted) begin
                    nextState = stAddress;
                end
            end
            stAddress: begin
                // ldi needs no memory access
                if (held.op == opLoadImm) begin
                    nextState = stWriteback;
                end else begin
                    nextState = stMemory;
                end
            end
            stMemory: begin
                nextState = stWriteback;
            end
            stWriteback, stRetire: begin
                if (retired) begin
                    nextState = stIdle;
                end else begin
                    nextState = stRetire;
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (accepted) begin
            held <= instr;
        end
        if (state == stMemory && held.op == opStore) begin
            storeData <= storeValue;    // Latched with the write
        end
    end

    // Register file reads and address add run side by side
    assign baseIndex = held.rb;
    assign dataIndex = held.ra;
    assign offset    = held.c;
    assign capture   = (state == stAddress);

    always_comb begin
        access.enable  = (state == stMemory);
        access.write   = (state == stMemory) && (held.op == opStore);
        access.address = effAddress;
        access.data    = storeValue;
    end

    always_comb begin
        case (held.op)
            opLoad:  resultValue = readData;
            opStore: resultValue = storeData;
            default: resultValue = effAddress;
        endcase
    end

    // Single write, on the edge that leaves stWriteback
    always_comb begin
        write.enable = (state == stWriteback) && (held.op != opStore);
        write.index  = held.ra;
        write.value  = resultValue;
    end

    always_comb begin
        retire.op      = held.op;
        retire.ra      = held.ra;
        retire.address = effAddress;
        retire.value   = resultValue;
    end

    legalOpcode: assert property (
        @(posedge Clock) disable iff (rst)
        accepted |-> (instr.op inside {opLoad, opLoadImm, opStore})
    ) else $error("illegal opcode %0d accepted", instr.op);

    // Record must not move while the consumer stalls
    retireHeld: assert property (
        @(posedge Clock) disable iff (rst)
        (retireValid && !retireReady) |=> (retireValid && $stable(retire))
    ) else $error("retire record changed under back-pressure");

endmodule

// ==== tb.f ====
+incdir+tb
logic/loadStorePkg.sv
logic/regFile.sv
logic/addressGen.sv
logic/dataMemory.sv
logic/sequencer.sv
logic/loadStoreCore.sv
tb/tbLoadStore.sv

// ==== tb/tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Architectural state as the instruction stream should leave it
dataWord shadowRegs [16];
dataWord shadowMem  [MemDepth];
bit      memWritten [MemDepth];
int      writtenWords [$];      // Word indices a load may target

function automatic void resetModel();
    for (int k = 0; k < 16; k++) begin
        shadowRegs[k] = '0;
    end
    for (int k = 0; k < MemDepth; k++) begin
        memWritten[k] = 1'b0;
    end
    writtenWords.delete();
endfunction

// r0 as a base means address zero
function automatic dataWord baseOf(regIndex rb);
    return (rb == 4'd0) ? '0 : shadowRegs[rb];
endfunction

function automatic dataWord extendC(displacement c);
    return {{13{c[18]}}, c};
endfunction

// Expected record for one instruction; advances the model past it
function automatic retireRecord expectRetire(instruction i);
    retireRecord             r;
    dataWord                 addr;
    logic [MemAddrWidth-1:0] word;
    addr      = baseOf(i.rb) + extendC(i.c);
    word      = addr[MemAddrWidth-1:0];     // Upper bits alias
    r.op      = i.op;
    r.ra      = i.ra;
    r.address = addr;
    case (i.op)
        opLoad: begin
            r.value          = shadowMem[word];
            shadowRegs[i.ra] = shadowMem[word];
        end
        opStore: begin
            r.value         = shadowRegs[i.ra];
            shadowMem[word] = shadowRegs[i.ra];
            if (!memWritten[word]) begin
                memWritten[word] = 1'b1;
                writtenWords.push_back(int'(word));
            end
        end
        default: begin
            r.value          = addr;
            shadowRegs[i.ra] = addr;
        end
    endcase
    return r;
endfunction

`endif

// ==== tb/tbLoadStore.sv ====
`timescale 1ns/1ps

module tbLoadStore;
    import loadStorePkg::*;

    localparam int MemAddrWidth = 9;
    localparam int MemDepth     = 2 ** MemAddrWidth;
    localparam int TotalInstr   = 16 + 4 + 6 + 4 + 40 + 200;
    localparam int TimeoutNs    = TotalInstr * 8 * 40 + 2000;

    logic        Clock = 1'b0;
    logic        rst;
    logic        instrValid;
    logic        instrReady;
    instruction  instr;
    logic        retireValid;
    logic        retireReady;
    retireRecord retire;

    retireRecord expectedQ [$];
    string       nameQ [$];
    int          mismatchCount = 0;
    int          otherErrors   = 0;
    int          retiredCount  = 0;
    logic        pressureOn    = 1'b0;

    `include "tbModel.svh"

    always #20 Clock = ~Clock;

    loadStoreCore #(
        .MemAddrWidth (MemAddrWidth)
    ) u_loadStoreCore (
        .Clock       (Clock),
        .rst         (rst),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .instr       (instr),
        .retireValid (retireValid),
        .retireReady (retireReady),
        .retire      (retire)
    );

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            mismatchCount++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic instruction makeInstr(opcode op, regIndex ra, regIndex rb,
                                             displacement c);
        instruction i;
        i.op = op;
        i.ra = ra;
        i.rb = rb;
        i.c  = c;
        return i;
    endfunction

    // Loads aim at a random alias of a word the model has written
    function automatic instruction randomInstr();
        instruction i;
        int         pick;
        dataWord    target;
        dataWord    diff;
        i.op = opcode'($urandom_range(2, 0));
        i.ra = regIndex'($urandom_range(15, 0));
        i.rb = regIndex'($urandom_range(15, 0));
        i.c  = displacement'($urandom);
        if (i.op == opLoad && writtenWords.size() == 0) begin
            i.op = opStore;
        end
        if (i.op == opLoad) begin
            pick   = $urandom_range(writtenWords.size() - 1, 0);
            target = dataWord'(writtenWords[pick])
                   + (dataWord'($urandom_range(7, 0)) << MemAddrWidth);
            diff   = target - baseOf(i.rb);
            if (diff[31:18] == '0 || diff[31:18] == '1) begin
                i.c = diff[18:0];
            end else begin
                i.rb = 4'd0;                // Base too far away
                i.c  = target[18:0];
            end
        end
        return i;
    endfunction

    // Entered and left 2 ns after a rising edge
    task automatic runInstr(input string name, input instruction i, input int gap);
        expectedQ.push_back(expectRetire(i));
        nameQ.push_back(name);
        instrValid = 1'b1;
        instr      = i;
        do @(negedge Clock); while (!instrReady);
        @(posedge Clock);
        #2;
        instrValid = 1'b0;
        repeat (gap) begin
            @(posedge Clock);
            #2;
        end
    endtask

    initial begin
        void'($urandom(86347));
        resetModel();
        rst         = 1'b1;
        instrValid  = 1'b0;
        instr       = '0;
        retireReady = 1'b1;
        repeat (3) @(posedge Clock);
        #2;
        rst = 1'b0;
        @(negedge Clock);
        checkValue("reset.instrReady", 32'd1, 32'(instrReady));
        checkValue("reset.retireValid", 32'd0, 32'(retireValid));
        @(posedge Clock);
        #2;

        for (int k = 0; k < 16; k++) begin      // Odd registers get negative C
            runInstr("ldiZeroBase", makeInstr(opLoadImm, regIndex'(k), 4'd0,
                displacement'((k % 2 == 1) ? -(k * 1000 + 7) : k * 4321 + 99)), 0);
        end

        runInstr("ldiBase", makeInstr(opLoadImm, 4'd3, 4'd5, displacement'(100)), 1);
        runInstr("ldiBase", makeInstr(opLoadImm, 4'd6, 4'd3, displacement'(7)), 0);
        runInstr("ldiBase", makeInstr(opLoadImm, 4'd5, 4'd5, displacement'(-200)), 2);
        runInstr("ldiBase", makeInstr(opLoadImm, 4'd7, 4'd5, displacement'(1)), 0);

        runInstr("storeLoad", makeInstr(opStore, 4'd9, 4'd0, displacement'(16)), 0);
        runInstr("storeLoad", makeInstr(opLoad, 4'd10, 4'd0, displacement'(16)), 0);
        runInstr("storeR0", makeInstr(opStore, 4'd0, 4'd2, displacement'(-8000)), 0);
        runInstr("storeR0", makeInstr(opLoad, 4'd11, 4'd2, displacement'(-8000)), 1);
        runInstr("storeLoad", makeInstr(opStore, 4'd13, 4'd1, displacement'(-5)), 0);
        runInstr("storeLoad", makeInstr(opLoad, 4'd14, 4'd1, displacement'(-5)), 0);

        // Addresses 40, 552, -472 and 1064 share one word
        runInstr("wrap", makeInstr(opStore, 4'd5, 4'd0, displacement'(40)), 0);
        runInstr("wrap", makeInstr(opLoad, 4'd15, 4'd0,
            displacement'(40 + (1 << MemAddrWidth))), 0);
        runInstr("wrap", makeInstr(opStore, 4'd6, 4'd0,
            displacement'(40 - (1 << MemAddrWidth))), 0);
        runInstr("wrap", makeInstr(opLoad, 4'd1, 4'd0,
            displacement'(40 + 2 * (1 << MemAddrWidth))), 0);

        pressureOn = 1'b1;
        for (int k = 0; k < 40; k++) begin
            runInstr("backPressure", randomInstr(), 0);
        end
        for (int k = 0; k < 200; k++) begin
            runInstr("randomMix", randomInstr(), $urandom_range(3, 0));
        end

        while (expectedQ.size() != 0) @(negedge Clock);
        repeat (2) @(negedge Clock);    // Room for a stray extra record to show
        checkValue("drain.retireValid", 32'd0, 32'(retireValid));
        checkValue("drain.instrReady", 32'd1, 32'(instrReady));
        $display("Summary: %0d retired, %0d mismatches, %0d other errors",
                 retiredCount, mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Consumer stalls of 0 to 4 cycles
    initial begin
        forever begin
            @(posedge Clock);
            #2;
            if (pressureOn && $urandom_range(2, 0) == 0) begin
                retireReady = 1'b0;
                repeat ($urandom_range(4, 0)) begin
                    @(posedge Clock);
                    #2;
                end
                retireReady = 1'b1;
            end
        end
    end

    // Handshakes seen at the falling edge complete on the next rising edge
    initial begin
        retireRecord exp;
        string       name;
        forever begin
            @(negedge Clock);
            if (!rst && retireValid && instrReady) begin
                otherErrors++;
                $display("ERROR: instruction port is ready while a retire record waits");
            end
            if (!rst && retireValid && retireReady) begin
                if (expectedQ.size() == 0) begin
                    otherErrors++;
                    $display("ERROR: retire record arrived with no instruction outstanding");
                end else begin
                    exp  = expectedQ.pop_front();
                    name = nameQ.pop_front();
                    checkValue({name, ".op"}, 32'(exp.op), 32'(retire.op));
                    checkValue({name, ".ra"}, 32'(exp.ra), 32'(retire.ra));
                    checkValue({name, ".address"}, exp.address, retire.address);
                    checkValue({name, ".value"}, exp.value, retire.value);
                    retiredCount++;
                end
            end
        end
    end

    initial begin
        #(TimeoutNs);
        otherErrors++;
        $display("ERROR: run timed out with %0d instructions still outstanding",
                 TotalInstr - retiredCount);
        $display("Summary: %0d retired, %0d mismatches, %0d other errors",
                 retiredCount, mismatchCount, otherErrors);
        $display("TB FAILED");
        $finish;
    end

endmodule
